// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= tb_rv_trace
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_rv_trace.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_trace;
  import rv_trace_pkg::*;

  localparam int    IMEM_WORDS = 64;
  localparam int    CREDITS    = 4;
  localparam int    AW         = $clog2(IMEM_WORDS);
  localparam addr_t PC_MASK    = addr_t'(IMEM_WORDS * 4 - 1);
  localparam int    NUM_RUNS   = 10;
  localparam int    WAIT_LIMIT = 2000;

  typedef struct packed {
    order_t    order;
    addr_t     pc;
    xlen_t     insn;
    inst_fmt_e fmt;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    xlen_t     imm;
    logic      last;
  } rec_t;

  logic        clk;
  logic        rst;
  logic        load_en;
  addr_t       load_addr;
  xlen_t       load_data;
  logic [3:0]  load_be;
  logic        start;
  addr_t       start_pc;
  logic [15:0] start_count;
  logic        credit_ret;
  logic        busy;
  logic        trace_valid;
  order_t      trace_order;
  addr_t       trace_pc;
  xlen_t       trace_insn;
  inst_fmt_e   trace_fmt;
  reg_idx_t    trace_rd;
  reg_idx_t    trace_rs1;
  reg_idx_t    trace_rs2;
  xlen_t       trace_imm;
  logic        trace_last;

  // reference copy of the program memory
  xlen_t       model_mem [IMEM_WORDS];
  rec_t        expect_q [$];
  logic [31:0] lfsr;
  order_t      next_order;
  int          received;
  int          returned;
  int          owed;
  logic        give;
  logic        started;
  logic        slow_credits;
  logic [6:0]  fmt_seen;

  rv_trace_top #(
    .IMEM_WORDS(IMEM_WORDS),
    .CREDITS   (CREDITS)
  ) rv_trace_top_inst (
    .clk        (clk),
    .rst        (rst),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .load_be    (load_be),
    .start      (start),
    .start_pc   (start_pc),
    .start_count(start_count),
    .busy       (busy),
    .trace_valid(trace_valid),
    .trace_order(trace_order),
    .trace_pc   (trace_pc),
    .trace_insn (trace_insn),
    .trace_fmt  (trace_fmt),
    .trace_rd   (trace_rd),
    .trace_rs1  (trace_rs1),
    .trace_rs2  (trace_rs2),
    .trace_imm  (trace_imm),
    .trace_last (trace_last),
    .credit_ret (credit_ret)
  );

  always #5 clk = ~clk;

  // galois lfsr, x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 32'h80200003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // mostly legal opcodes, the rest left random
  function automatic xlen_t random_word();
    xlen_t      w;
    logic [3:0] pick;
    w    = rand_bits(32);
    pick = 4'(rand_bits(4));
    case (pick)
      4'd0:    w[6:0] = 7'b0110111;
      4'd1:    w[6:0] = 7'b0010111;
      4'd2:    w[6:0] = 7'b1101111;
      4'd3:    w[6:0] = 7'b1100111;
      4'd4:    w[6:0] = 7'b1100011;
      4'd5:    w[6:0] = 7'b0000011;
      4'd6:    w[6:0] = 7'b0100011;
      4'd7:    w[6:0] = 7'b0010011;
      4'd8:    w[6:0] = 7'b0110011;
      4'd9:    w[6:0] = 7'b0001111;
      4'd10:   w[6:0] = 7'b1110011;
      default: w[6:0] = w[6:0];
    endcase
    return w;
  endfunction

  function automatic rec_t model_record(input addr_t pc, input order_t ord, input logic last);
    rec_t  r;
    xlen_t w;
    w       = model_mem[pc[AW+1:2]];
    r.order = ord;
    r.pc    = pc;
    r.insn  = w;
    r.last  = last;
    case (w[6:0])
      7'b0110111, 7'b0010111: r.fmt = fmt_u;
      7'b1101111:             r.fmt = fmt_j;
      7'b1100111, 7'b0000011, 7'b0010011, 7'b0001111, 7'b1110011: r.fmt = fmt_i;
      7'b1100011:             r.fmt = fmt_b;
      7'b0100011:             r.fmt = fmt_s;
      7'b0110011:             r.fmt = fmt_r;
      default:                r.fmt = fmt_bad;
    endcase
    case (r.fmt)
      fmt_i:   r.imm = xlen_t'($signed(w[31:20]));
      fmt_s:   r.imm = xlen_t'($signed({w[31:25], w[11:7]}));
      fmt_b:   r.imm = xlen_t'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      fmt_u:   r.imm = {w[31:12], 12'h000};
      fmt_j:   r.imm = xlen_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default: r.imm = '0;
    endcase
    r.rd  = (r.fmt inside {fmt_r, fmt_i, fmt_u, fmt_j}) ? w[11:7] : 5'd0;
    r.rs1 = (r.fmt inside {fmt_r, fmt_i, fmt_s, fmt_b}) ? w[19:15] : 5'd0;
    r.rs2 = (r.fmt inside {fmt_r, fmt_s, fmt_b}) ? w[24:20] : 5'd0;
    return r;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR %0t ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR %0t ns %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_fmt(input string name, input inst_fmt_e got, input inst_fmt_e exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR %0t ns %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_order(input string name, input order_t got, input order_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR %0t ns %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic write_word(input addr_t idx, input xlen_t data, input logic [3:0] be);
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= idx;
    load_data <= data;
    load_be   <= be;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model_mem[idx[AW-1:0]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // partial writes over words already loaded
  task automatic scramble_bytes(input int n);
    addr_t      idx;
    xlen_t      data;
    logic [3:0] be;
    for (int i = 0; i < n; i++) begin
      idx  = addr_t'(rand_bits(AW));
      data = random_word();
      be   = 4'(rand_bits(4));
      write_word(idx, data, be);
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic run_words(input addr_t pc0, input int count);
    addr_t pc;
    int    waited;
    pc = pc0;
    for (int i = 0; i < count; i++) begin
      expect_q.push_back(model_record(pc, next_order, i == count - 1));
      next_order++;
      pc = (pc + 32'd4) & PC_MASK;
    end
    @(posedge clk);
    start       <= 1'b1;
    start_pc    <= pc0;
    start_count <= 16'(count);
    started     = 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_word("busy", xlen_t'(busy), 32'd1);
    waited = 0;
    while (expect_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_now("timeout while waiting for the trace records of a run");
      end
    end
  endtask

  // trace monitor and credit decisions, sampled mid-cycle
  always @(negedge clk) begin
    rec_t e;
    if (rst) begin
      give = 1'b0;
    end else begin
      if (!started) begin
        check_word("busy", xlen_t'(busy), 32'd0);
        check_word("trace_valid", xlen_t'(trace_valid), 32'd0);
      end
      if (trace_valid === 1'b1) begin
        if (expect_q.size() == 0) begin
          fail_now("a trace record arrived when none was expected");
        end else begin
          e = expect_q.pop_front();
          check_order("trace_order", trace_order, e.order);
          check_word("trace_pc", trace_pc, e.pc);
          check_word("trace_insn", trace_insn, e.insn);
          check_fmt("trace_fmt", trace_fmt, e.fmt);
          check_reg("trace_rd", trace_rd, e.rd);
          check_reg("trace_rs1", trace_rs1, e.rs1);
          check_reg("trace_rs2", trace_rs2, e.rs2);
          check_word("trace_imm", trace_imm, e.imm);
          check_word("trace_last", xlen_t'(trace_last), xlen_t'(e.last));
          fmt_seen[e.fmt] = 1'b1;
          received++;
          owed++;
        end
      end
      if (received - returned > CREDITS) begin
        fail_now("more trace records outstanding than credits");
      end
      give = 1'b0;
      if (owed > 0 && (!slow_credits || rand_bits(2) == 32'd0)) begin
        give = 1'b1;
        owed--;
        returned++;
      end
    end
  end

  always @(posedge clk) begin
    credit_ret <= give;
  end

  initial begin
    xlen_t data;
    int    start_word;
    int    count;
    clk          = 1'b0;
    rst          = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    load_be      = '0;
    start        = 1'b0;
    start_pc     = '0;
    start_count  = '0;
    credit_ret   = 1'b0;
    lfsr         = 32'h46490213;
    next_order   = '0;
    received     = 0;
    returned     = 0;
    owed         = 0;
    give         = 1'b0;
    started      = 1'b0;
    slow_credits = 1'b0;
    fmt_seen     = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // full words first, so no lane is left undefined
    for (int i = 0; i < IMEM_WORDS; i++) begin
      data = random_word();
      write_word(addr_t'(i), data, 4'hF);
    end
    scramble_bytes(24);
    for (int r = 0; r < NUM_RUNS; r++) begin
      slow_credits = r[0];
      if (r == 0) begin
        // first run crosses the top of memory
        start_word = IMEM_WORDS - 4;
        count      = 12;
      end else begin
        start_word = int'(rand_bits(AW));
        count      = int'(rand_bits(5)) + 1;
      end
      run_words(addr_t'(start_word * 4), count);
      scramble_bytes(6);
    end
    repeat (5) @(posedge clk);
    if (fmt_seen != 7'h7F) begin
      fail_now("not every instruction format appeared in the trace");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
src/rv_trace_pkg.sv
src/fetch_if.sv
src/lane_imem.sv
src/fetch_ctrl.sv
src/credit_counter.sv
src/rv_decode.sv
src/rv_trace_top.sv
bench/tb_rv_trace.sv

// File: src/credit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module credit_counter #(
  parameter int CREDITS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic take,
  input  logic ret,
  output logic avail
);

  localparam int CW = $clog2(CREDITS + 1);

  logic [CW-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= CW'(CREDITS);
    end else if (take && !ret) begin
      count <= count - 1'b1;
    end else if (ret && !take) begin
      count <= count + 1'b1;
    end
  end

  // registered count, so a returned credit is usable next cycle
  assign avail = (count != '0);

endmodule

`default_nettype wire

// File: src/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  rv_trace_pkg::addr_t start_pc,
  input  logic [15:0]         start_count,
  input  logic                credit_avail,
  output logic                credit_take,
  output logic                busy,
  fetch_if.ctrl               f
);
  import rv_trace_pkg::*;

  // byte pc wraps at the memory size, depth is a power of two
  localparam addr_t PC_MASK = addr_t'(IMEM_WORDS * 4 - 1);

  typedef enum logic {
    idle,
    run
  } state_e;

  state_e      state;
  addr_t       pc;
  logic [15:0] remaining;
  order_t      order;
  logic        issue;

  // one word per cycle while a credit is held
  assign issue       = (state == run) && credit_avail;
  assign credit_take = issue;
  assign busy        = (state == run);

  assign f.req_valid = issue;
  assign f.req_pc    = pc;
  assign f.req_order = order;
  assign f.req_last  = (remaining == 16'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      remaining <= '0;
      order     <= '0;
    end else begin
      case (state)
        idle: begin
          // a zero-length run never leaves idle
          if (start && start_count != 16'd0) begin
            state     <= run;
            remaining <= start_count;
          end
        end
        run: begin
          if (issue) begin
            remaining <= remaining - 16'd1;
            if (remaining == 16'd1) begin
              state <= idle;
            end
          end
        end
        default: state <= idle;
      endcase
      // order keeps counting across runs
      if (issue) begin
        order <= order + 64'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && start) begin
      pc <= start_pc & PC_MASK;
    end else if (issue) begin
      pc <= (pc + addr_t'(4)) & PC_MASK;
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fetch_if;
  import rv_trace_pkg::*;

  // request, fetch controller to memory
  logic   req_valid;
  addr_t  req_pc;
  order_t req_order;
  logic   req_last;

  // response, memory to decoder, one cycle behind its request
  logic   rsp_valid;
  addr_t  rsp_pc;
  order_t rsp_order;
  logic   rsp_last;
  xlen_t  rsp_insn;

  modport ctrl (
    output req_valid, req_pc, req_order, req_last
  );

  modport mem (
    input  req_valid, req_pc, req_order, req_last,
    output rsp_valid, rsp_pc, rsp_order, rsp_last, rsp_insn
  );

  modport dec (
    input rsp_valid, rsp_pc, rsp_order, rsp_last, rsp_insn
  );

endinterface

`default_nettype wire

// File: src/lane_imem.sv
`timescale 1ns/1ns
`default_nettype none

module lane_imem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                load_en,
  input  rv_trace_pkg::addr_t load_addr,
  input  rv_trace_pkg::xlen_t load_data,
  input  logic [3:0]          load_be,
  fetch_if.mem                f
);

  localparam int AW = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1;

  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;

  assign wr_idx = load_addr[AW-1:0];
  // word index from the byte pc
  assign rd_idx = f.req_pc[AW+1:2];

  // one byte array per lane, lane 0 holds bits 7:0
  for (genvar i = 0; i < 4; i++) begin : g_lane
    logic [7:0] mem [IMEM_WORDS];
    logic [7:0] rd_q;

    always_ff @(posedge clk) begin
      if (load_en && load_be[i]) begin
        mem[wr_idx] <= load_data[8*i +: 8];
      end
      if (f.req_valid) begin
        rd_q <= mem[rd_idx];
      end
    end
  end

  assign f.rsp_insn = {g_lane[3].rd_q, g_lane[2].rd_q, g_lane[1].rd_q, g_lane[0].rd_q};

  // tags follow the read data by one cycle
  always_ff @(posedge clk) begin
    if (f.req_valid) begin
      f.rsp_pc    <= f.req_pc;
      f.rsp_order <= f.req_order;
      f.rsp_last  <= f.req_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      f.rsp_valid <= 1'b0;
    end else begin
      f.rsp_valid <= f.req_valid;
    end
  end

endmodule

`default_nettype wire

// File: src/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
  input  logic                    clk,
  input  logic                    rst,
  fetch_if.dec                    f,
  output logic                    trace_valid,
  output rv_trace_pkg::order_t    trace_order,
  output rv_trace_pkg::addr_t     trace_pc,
  output rv_trace_pkg::xlen_t     trace_insn,
  output rv_trace_pkg::inst_fmt_e trace_fmt,
  output rv_trace_pkg::reg_idx_t  trace_rd,
  output rv_trace_pkg::reg_idx_t  trace_rs1,
  output rv_trace_pkg::reg_idx_t  trace_rs2,
  output rv_trace_pkg::xlen_t     trace_imm,
  output logic                    trace_last
);
  import rv_trace_pkg::*;

  xlen_t     insn;
  opcode_t   opcode;
  inst_fmt_e fmt;
  xlen_t     imm;
  reg_idx_t  rd;
  reg_idx_t  rs1;
  reg_idx_t  rs2;

  assign insn   = f.rsp_insn;
  assign opcode = insn[6:0];

  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: fmt = fmt_u;
      OP_JAL:           fmt = fmt_j;
      OP_JALR, OP_LOAD, OP_IMM, OP_MISC_MEM, OP_SYSTEM: begin
        fmt = fmt_i;
      end
      OP_BRANCH:        fmt = fmt_b;
      OP_STORE:         fmt = fmt_s;
      OP_REG:           fmt = fmt_r;
      default:          fmt = fmt_bad;
    endcase
  end

  // sign-extended immediate, insn[31] is always the sign bit
  always_comb begin
    case (fmt)
      fmt_i:   imm = {{20{insn[31]}}, insn[31:20]};
      fmt_s:   imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      fmt_b:   imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      fmt_u:   imm = {insn[31:12], 12'b0};
      fmt_j:   imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // zero the register fields a format does not carry
  always_comb begin
    rd  = (fmt == fmt_r || fmt == fmt_i || fmt == fmt_u || fmt == fmt_j) ? insn[11:7] : '0;
    rs1 = (fmt == fmt_r || fmt == fmt_i || fmt == fmt_s || fmt == fmt_b) ? insn[19:15] : '0;
    rs2 = (fmt == fmt_r || fmt == fmt_s || fmt == fmt_b) ? insn[24:20] : '0;
  end

  always_ff @(posedge clk) begin
    if (f.rsp_valid) begin
      trace_order <= f.rsp_order;
      trace_pc    <= f.rsp_pc;
      trace_insn  <= insn;
      trace_fmt   <= fmt;
      trace_rd    <= rd;
      trace_rs1   <= rs1;
      trace_rs2   <= rs2;
      trace_imm   <= imm;
      trace_last  <= f.rsp_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= f.rsp_valid;
    end
  end

endmodule

`default_nettype wire

// File: src/rv_trace_pkg.sv
`default_nettype none

package rv_trace_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [63:0] order_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // RV32I major opcodes, insn[6:0]
  localparam opcode_t OP_LUI      = 7'b0110111;
  localparam opcode_t OP_AUIPC    = 7'b0010111;
  localparam opcode_t OP_JAL      = 7'b1101111;
  localparam opcode_t OP_JALR     = 7'b1100111;
  localparam opcode_t OP_BRANCH   = 7'b1100011;
  localparam opcode_t OP_LOAD     = 7'b0000011;
  localparam opcode_t OP_STORE    = 7'b0100011;
  localparam opcode_t OP_IMM      = 7'b0010011;
  localparam opcode_t OP_REG      = 7'b0110011;
  localparam opcode_t OP_MISC_MEM = 7'b0001111;
  localparam opcode_t OP_SYSTEM   = 7'b1110011;

  // instruction encoding formats
  typedef enum logic [2:0] {
    fmt_r,
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j,
    fmt_bad
  } inst_fmt_e;

endpackage

`default_nettype wire

// File: src/rv_trace_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_trace_top #(
  parameter int IMEM_WORDS = 256,
  parameter int CREDITS    = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  // host program load, load_addr is a word index
  input  logic                    load_en,
  input  rv_trace_pkg::addr_t     load_addr,
  input  rv_trace_pkg::xlen_t     load_data,
  input  logic [3:0]              load_be,
  // run command
  input  logic                    start,
  input  rv_trace_pkg::addr_t     start_pc,
  input  logic [15:0]             start_count,
  output logic                    busy,
  // trace records
  output logic                    trace_valid,
  output rv_trace_pkg::order_t    trace_order,
  output rv_trace_pkg::addr_t     trace_pc,
  output rv_trace_pkg::xlen_t     trace_insn,
  output rv_trace_pkg::inst_fmt_e trace_fmt,
  output rv_trace_pkg::reg_idx_t  trace_rd,
  output rv_trace_pkg::reg_idx_t  trace_rs1,
  output rv_trace_pkg::reg_idx_t  trace_rs2,
  output rv_trace_pkg::xlen_t     trace_imm,
  output logic                    trace_last,
  input  logic                    credit_ret
);

  logic credit_avail;
  logic credit_take;

  fetch_if fetch_bus ();

  fetch_ctrl #(
    .IMEM_WORDS(IMEM_WORDS)
  ) fetch_ctrl_inst (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .start_pc    (start_pc),
    .start_count (start_count),
    .credit_avail(credit_avail),
    .credit_take (credit_take),
    .busy        (busy),
    .f           (fetch_bus.ctrl)
  );

  credit_counter #(
    .CREDITS(CREDITS)
  ) credit_counter_inst (
    .clk  (clk),
    .rst  (rst),
    .take (credit_take),
    .ret  (credit_ret),
    .avail(credit_avail)
  );

  lane_imem #(
    .IMEM_WORDS(IMEM_WORDS)
  ) lane_imem_inst (
    .clk      (clk),
    .rst      (rst),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .load_be  (load_be),
    .f        (fetch_bus.mem)
  );

  rv_decode rv_decode_inst (
    .clk        (clk),
    .rst        (rst),
    .f          (fetch_bus.dec),
    .trace_valid(trace_valid),
    .trace_order(trace_order),
    .trace_pc   (trace_pc),
    .trace_insn (trace_insn),
    .trace_fmt  (trace_fmt),
    .trace_rd   (trace_rd),
    .trace_rs1  (trace_rs1),
    .trace_rs2  (trace_rs2),
    .trace_imm  (trace_imm),
    .trace_last (trace_last)
  );

endmodule

`default_nettype wire
